//--- all.f
+incdir+design
+incdir+testbench
design/ibtb_pkg.sv
design/ibtb_update_if.sv
design/distram_1rport_1wport.sv
design/ibtb.sv
design/ibtb_history.sv
design/ibtb_predictor.sv
testbench/ibtb_predictor_tb.sv

//--- Makefile
# Verilator build, run and lint for the indirect target predictor slice

TOP := ibtb_predictor_tb

.PHONY: all lint clean

# build, run, and fail unless the pass message shows up
all:
	verilator --binary --timing -f all.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/ibtb_predictor_tb_tasks.svh
// ------------------------------
// directed tests and typed compare tasks
// included inside the testbench module
// ------------------------------

task automatic check_info(ibtb_info_t actual, ibtb_info_t expected, string name);
    check_count++;
    if (actual !== expected) begin
        $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        error_count++;
    end
endtask

task automatic check_gh(ibtb_gh_t actual, ibtb_gh_t expected, string name);
    check_count++;
    if (actual !== expected) begin
        $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        error_count++;
    end
endtask

task automatic test_after_reset();
    @(negedge CLK);
    check_gh(read_ibtb_gh, '0, "read_ibtb_gh");
endtask

// target picked so the fold leaves the history unchanged
task automatic test_write_then_read();
    pc38_t      pc;
    asid_t      asid;
    ibtb_gh_t   gh_before;
    ibtb_info_t info;
    pc        = rand_pc();
    asid      = rand_asid();
    gh_before = model_gh;
    info.tgt_pc38 = rand_pc();
    info.tgt_pc38[GH_W-1:0] = gh_before ^ ibtb_gh_t'({gh_before, 1'b0});
    apply_update(pc, gh_before, asid, info);
    read_and_check(pc, asid);
    check_info(read_tgt_ibtb_info, info, "read_tgt_ibtb_info");
    check_gh(read_ibtb_gh, gh_before, "read_ibtb_gh");
endtask

task automatic test_index_aliasing();
    pc38_t      pc_a;
    pc38_t      pc_b;
    asid_t      asid_a;
    asid_t      asid_b;
    ibtb_gh_t   gh_b;
    ibtb_idx_t  idx;
    ibtb_info_t info_a;
    ibtb_info_t info_b;
    pc_a   = rand_pc();
    asid_a = rand_asid();
    // differs in the top asid bit, outside the hash
    asid_b = asid_a ^ 9'h100;
    gh_b   = ibtb_gh_t'($urandom());
    idx    = expected_index(pc_a, model_gh, asid_a);
    pc_b   = rand_pc();
    pc_b[IDX_W-1:0] = idx ^ gh_b ^ asid_b[IDX_W-1:0];
    info_a.tgt_pc38 = rand_pc();
    info_b.tgt_pc38 = rand_pc();
    apply_update(pc_a, model_gh, asid_a, info_a);
    apply_update(pc_b, gh_b, asid_b, info_b);
    read_and_check(pc_for_index(idx, pc_a, asid_a), asid_a);
    check_info(read_tgt_ibtb_info, info_b, "read_tgt_ibtb_info");
    read_and_check(pc_for_index(idx, pc_b, asid_b), asid_b);
    check_info(read_tgt_ibtb_info, info_b, "read_tgt_ibtb_info");
endtask

task automatic test_history_evolution();
    ibtb_info_t info;
    repeat (HIST_UPDATES) begin
        info.tgt_pc38 = rand_pc();
        apply_update(rand_pc(), ibtb_gh_t'($urandom()), rand_asid(), info);
        @(negedge CLK);
        check_gh(read_ibtb_gh, model_gh, "read_ibtb_gh");
    end
endtask

// old data in the update cycle, new data one cycle later
task automatic test_read_during_update();
    pc38_t      pc;
    asid_t      asid;
    ibtb_idx_t  idx;
    ibtb_info_t old_info;
    ibtb_info_t new_info;
    pc   = rand_pc();
    asid = rand_asid();
    idx  = expected_index(pc, model_gh, asid);
    old_info.tgt_pc38 = rand_pc();
    new_info.tgt_pc38 = rand_pc();
    apply_update(pc, model_gh, asid, old_info);
    @(posedge CLK);
    update_valid         <= 1'b1;
    update_src_pc38      <= pc_for_index(idx, pc, asid);
    update_ibtb_gh       <= model_gh;
    update_asid          <= asid;
    update_tgt_ibtb_info <= new_info;
    read_src_pc38        <= pc_for_index(idx, rand_pc(), asid);
    read_asid            <= asid;
    @(negedge CLK);
    check_info(read_tgt_ibtb_info, old_info, "read_tgt_ibtb_info");
    @(posedge CLK);
    update_valid <= 1'b0;
    model_array[idx] = new_info;
    model_gh = expected_history(model_gh, new_info.tgt_pc38);
    read_src_pc38 <= pc_for_index(idx, rand_pc(), asid);
    @(negedge CLK);
    check_info(read_tgt_ibtb_info, new_info, "read_tgt_ibtb_info");
    check_gh(read_ibtb_gh, model_gh, "read_ibtb_gh");
endtask

task automatic test_random_mix();
    int         pool [ENTRIES];
    int         j;
    int         tmp;
    pc38_t      pc;
    asid_t      asid;
    ibtb_gh_t   gh;
    ibtb_info_t info;
    for (int i = 0; i < ENTRIES; i++) begin
        pool[i] = i;
    end
    // shuffle so the first MIX_UPDATES indices are distinct
    for (int i = ENTRIES - 1; i > 0; i--) begin
        j       = int'($urandom() % (i + 1));
        tmp     = pool[i];
        pool[i] = pool[j];
        pool[j] = tmp;
    end
    for (int i = 0; i < MIX_UPDATES; i++) begin
        asid = rand_asid();
        gh   = ibtb_gh_t'($urandom());
        pc   = rand_pc();
        pc[IDX_W-1:0] = ibtb_idx_t'(pool[i]) ^ gh ^ asid[IDX_W-1:0];
        info.tgt_pc38 = rand_pc();
        apply_update(pc, gh, asid, info);
    end
    for (int i = 0; i < MIX_UPDATES; i++) begin
        asid = rand_asid();
        read_and_check(pc_for_index(ibtb_idx_t'(pool[i]), rand_pc(), asid), asid);
    end
endtask

//--- testbench/ibtb_predictor_tb.sv
// ------------------------------
// testbench for the indirect target predictor slice
// reference model of array and history, directed tests
// ------------------------------

`default_nettype none

module ibtb_predictor_tb import ibtb_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int IDX_W        = $bits(ibtb_idx_t);
    localparam int GH_W         = $bits(ibtb_gh_t);
    localparam int ENTRIES      = 2 ** IDX_W;
    localparam int HIST_UPDATES = 24;
    localparam int MIX_UPDATES  = 200;

    // reset, then each test in order, in clock cycles
    localparam int TEST_CYCLES  = 8 + 2 + 4 + 8 + 2 * HIST_UPDATES + 6 + 3 * MIX_UPDATES;

    logic       CLK;
    logic       arst_n;
    pc38_t      read_src_pc38;
    asid_t      read_asid;
    ibtb_gh_t   read_ibtb_gh;
    ibtb_info_t read_tgt_ibtb_info;
    logic       update_valid;
    pc38_t      update_src_pc38;
    ibtb_gh_t   update_ibtb_gh;
    asid_t      update_asid;
    ibtb_info_t update_tgt_ibtb_info;

    // ------------------------------
    // reference model

    ibtb_info_t model_array [ibtb_idx_t];
    ibtb_gh_t   model_gh;

    int error_count;
    int check_count;

    // low pc, history and low asid bits xor-ed together
    function automatic ibtb_idx_t expected_index(pc38_t pc, ibtb_gh_t gh, asid_t asid);
        return ibtb_idx_t'(pc[IDX_W-1:0] ^ gh[IDX_W-1:0] ^ asid[IDX_W-1:0]);
    endfunction

    // shift in a zero, old top bit falls off, fold in low target bits
    function automatic ibtb_gh_t expected_history(ibtb_gh_t gh, pc38_t tgt);
        return ibtb_gh_t'({gh, 1'b0}) ^ tgt[GH_W-1:0];
    endfunction

    function automatic pc38_t rand_pc();
        return pc38_t'({$urandom(), $urandom()});
    endfunction

    function automatic asid_t rand_asid();
        return asid_t'($urandom());
    endfunction

    // pc that lands on idx under the current history
    function automatic pc38_t pc_for_index(ibtb_idx_t idx, pc38_t base, asid_t asid);
        pc38_t pc;
        pc = base;
        pc[IDX_W-1:0] = idx ^ model_gh[IDX_W-1:0] ^ asid[IDX_W-1:0];
        return pc;
    endfunction

    // one update strobe, model follows on the write edge
    task automatic apply_update(pc38_t pc, ibtb_gh_t gh, asid_t asid, ibtb_info_t info);
        ibtb_idx_t idx;
        idx = expected_index(pc, gh, asid);
        @(posedge CLK);
        update_valid         <= 1'b1;
        update_src_pc38      <= pc;
        update_ibtb_gh       <= gh;
        update_asid          <= asid;
        update_tgt_ibtb_info <= info;
        @(posedge CLK);
        update_valid <= 1'b0;
        model_array[idx] = info;
        model_gh = expected_history(model_gh, info.tgt_pc38);
    endtask

    // read a written entry and compare with the model
    task automatic read_and_check(pc38_t pc, asid_t asid);
        ibtb_idx_t idx;
        idx = expected_index(pc, model_gh, asid);
        @(posedge CLK);
        read_src_pc38 <= pc;
        read_asid     <= asid;
        @(negedge CLK);
        check_gh(read_ibtb_gh, model_gh, "read_ibtb_gh");
        if (model_array.exists(idx)) begin
            check_info(read_tgt_ibtb_info, model_array[idx], "read_tgt_ibtb_info");
        end else begin
            $display("read of index %0d, which was never written", idx);
            error_count++;
        end
    endtask

    `include "ibtb_predictor_tb_tasks.svh"

    // ------------------------------
    // DUT

    ibtb_predictor DUT (
        .CLK                  (CLK),
        .arst_n               (arst_n),
        .read_src_pc38        (read_src_pc38),
        .read_asid            (read_asid),
        .read_ibtb_gh         (read_ibtb_gh),
        .read_tgt_ibtb_info   (read_tgt_ibtb_info),
        .update_valid         (update_valid),
        .update_src_pc38      (update_src_pc38),
        .update_ibtb_gh       (update_ibtb_gh),
        .update_asid          (update_asid),
        .update_tgt_ibtb_info (update_tgt_ibtb_info)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", TEST_CYCLES + 50);
        $display("sim failed");
        $finish;
    end

    // ------------------------------
    // test sequence

    initial begin
        arst_n               = 1'b0;
        read_src_pc38        = '0;
        read_asid            = '0;
        update_valid         = 1'b0;
        update_src_pc38      = '0;
        update_ibtb_gh       = '0;
        update_asid          = '0;
        update_tgt_ibtb_info = '0;
        model_gh             = '0;
        error_count          = 0;
        check_count          = 0;
        void'($urandom(94));

        repeat (8) @(posedge CLK);
        arst_n <= 1'b1;

        test_after_reset();
        test_write_then_read();
        test_index_aliasing();
        test_history_evolution();
        test_read_during_update();
        test_random_mix();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/ibtb_predictor.sv
// ------------------------------
// indirect target predictor top, plain ports in
// joins the update bus, history register and buffer
// ------------------------------

`default_nettype none

module ibtb_predictor import ibtb_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,

    // read
    input  pc38_t      read_src_pc38,
    input  asid_t      read_asid,
    output ibtb_gh_t   read_ibtb_gh,
    output ibtb_info_t read_tgt_ibtb_info,

    // update, gh is the one exported with the read
    input  logic       update_valid,
    input  pc38_t      update_src_pc38,
    input  ibtb_gh_t   update_ibtb_gh,
    input  asid_t      update_asid,
    input  ibtb_info_t update_tgt_ibtb_info
);

    // ------------------------------
    // update bus

    ibtb_update_if update_bus ();

    assign update_bus.valid    = update_valid;
    assign update_bus.src_pc38 = update_src_pc38;
    assign update_bus.gh       = update_ibtb_gh;
    assign update_bus.asid     = update_asid;
    assign update_bus.tgt_info = update_tgt_ibtb_info;

    // ------------------------------
    // history

    ibtb_gh_t cur_gh;

    ibtb_history u_history (
        .CLK    (CLK),
        .arst_n (arst_n),
        .update (update_bus.sink),
        .cur_gh (cur_gh)
    );

    // caller hands this back with the update
    assign read_ibtb_gh = cur_gh;

    // ------------------------------
    // target buffer

    ibtb u_ibtb (
        .CLK                (CLK),
        .read_src_pc38      (read_src_pc38),
        .read_ibtb_gh       (cur_gh),
        .read_asid          (read_asid),
        .read_tgt_ibtb_info (read_tgt_ibtb_info),
        .update             (update_bus.sink)
    );

endmodule

`default_nettype wire

//--- design/ibtb_history.sv
// ------------------------------
// indirect target global history register
// folds each resolved target into gh on the update edge
// ------------------------------

`default_nettype none

module ibtb_history import ibtb_pkg::*; (
    input  logic        CLK,
    input  logic        arst_n,

    // resolved updates, only valid and target are used
    ibtb_update_if.sink update,

    // history for the next read
    output ibtb_gh_t    cur_gh
);

    // ------------------------------
    // history rule

    // shift left with zero fill, then xor in low target bits
    function automatic ibtb_gh_t fold_target(
        input ibtb_gh_t gh,
        input pc38_t    tgt_pc38
    );
        ibtb_gh_t shifted;
        shifted = {gh[$bits(ibtb_gh_t)-2:0], 1'b0};
        return shifted ^ tgt_pc38[$bits(ibtb_gh_t)-1:0];
    endfunction

    // ------------------------------
    // register

    ibtb_gh_t gh_q;
    ibtb_gh_t gh_next;

    // the update's own gh field is for indexing only
    always_comb begin
        gh_next = gh_q;
        if (update.valid) begin
            gh_next = fold_target(gh_q, update.tgt_info.tgt_pc38);
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            gh_q <= '0;
        end else begin
            gh_q <= gh_next;
        end
    end

    // new history visible the cycle after the update
    assign cur_gh = gh_q;

endmodule

`default_nettype wire

//--- design/ibtb.sv
// ------------------------------
// indirect branch target buffer, hashed pc/gh/asid index
// combinational read, update strobe writes the target
// ------------------------------

`default_nettype none

`include "ibtb_defs.svh"

module ibtb import ibtb_pkg::*; (
    input  logic        CLK,

    // read
    input  pc38_t       read_src_pc38,
    input  ibtb_gh_t    read_ibtb_gh,
    input  asid_t       read_asid,
    output ibtb_info_t  read_tgt_ibtb_info,

    // update
    ibtb_update_if.sink update
);

    // ------------------------------
    // index hash

    // low pc bits ^ history ^ low asid bits
    function automatic ibtb_idx_t index_hash(
        input pc38_t    pc38,
        input ibtb_gh_t gh,
        input asid_t    asid
    );
        ibtb_idx_t idx;
        idx = pc38[$bits(ibtb_idx_t)-1:0];
        idx ^= gh[$bits(ibtb_idx_t)-1:0];
        idx ^= asid[$bits(ibtb_idx_t)-1:0];
        return idx;
    endfunction

    // ------------------------------
    // array signals

    ibtb_idx_t  array_read_index;
    ibtb_info_t array_read_data;

    logic       array_write_en;
    ibtb_idx_t  array_write_index;
    ibtb_info_t array_write_data;

    // read side
    always_comb begin
        array_read_index   = index_hash(read_src_pc38, read_ibtb_gh, read_asid);
        read_tgt_ibtb_info = array_read_data;
    end

    // write side, same hash on the returned triple
    always_comb begin
        array_write_en    = update.valid;
        array_write_index = index_hash(update.src_pc38, update.gh, update.asid);
        array_write_data  = update.tgt_info;
    end

    // ------------------------------
    // target array

    distram_1rport_1wport #(
        .INNER_WIDTH($bits(ibtb_info_t)),
        .OUTER_WIDTH(`IBTB_ENTRIES)
    ) u_array (
        .CLK    (CLK),
        .rindex (array_read_index),
        .rdata  (array_read_data),
        .wen    (array_write_en),
        .windex (array_write_index),
        .wdata  (array_write_data)
    );

endmodule

`default_nettype wire

//--- design/distram_1rport_1wport.sv
// ------------------------------
// lut-ram style array, async read and clocked write
// sized only through its two width parameters
// ------------------------------

`default_nettype none

module distram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 16
) (
    input  logic                           CLK,

    // read port
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    // write port
    input  logic                           wen,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    // ------------------------------
    // storage

    // no reset, contents undefined until written
    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ------------------------------
    // read

    // combinational, sees a write only after its edge
    always_comb begin
        rdata = mem[rindex];
    end

    // ------------------------------
    // write

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/ibtb_update_if.sv
// ------------------------------
// resolved indirect branch update bus
// one strobe per clock, receivers cannot stall it
// ------------------------------

`default_nettype none

interface ibtb_update_if import ibtb_pkg::*; ();

    // one-cycle update strobe
    logic       valid;

    // index triple of the resolved branch
    pc38_t      src_pc38;
    ibtb_gh_t   gh;
    asid_t      asid;

    // resolved target
    ibtb_info_t tgt_info;

    // driven from the top-level update ports
    modport source (
        output valid,
        output src_pc38,
        output gh,
        output asid,
        output tgt_info
    );

    // buffer write port and history register
    modport sink (
        input valid,
        input src_pc38,
        input gh,
        input asid,
        input tgt_info
    );

endinterface

`default_nettype wire

//--- design/ibtb_pkg.sv
// ------------------------------
// shared types of the indirect target predictor slice
// import with a wildcard in the module header
// ------------------------------

`default_nettype none

`include "ibtb_defs.svh"

package ibtb_pkg;

    // ------------------------------
    // scalar types

    typedef logic [`IBTB_PC_WIDTH-1:0] pc38_t;

    typedef logic [`IBTB_GH_WIDTH-1:0] ibtb_gh_t;

    typedef logic [`IBTB_ASID_WIDTH-1:0] asid_t;

    // array index, 8 bits for 256 entries
    typedef logic [$clog2(`IBTB_ENTRIES)-1:0] ibtb_idx_t;

    // ------------------------------
    // entry payload

    // single field today, room for more later
    typedef struct packed {
        pc38_t tgt_pc38;
    } ibtb_info_t;

endpackage

`default_nettype wire

//--- design/ibtb_defs.svh
// ------------------------------
// size constants for the indirect target predictor slice
// included by the package and by the buffer
// ------------------------------

`ifndef IBTB_DEFS_SVH
`define IBTB_DEFS_SVH

// source and target pc width
`define IBTB_PC_WIDTH 38

// indirect target global history width
`define IBTB_GH_WIDTH 8

// address space id width
`define IBTB_ASID_WIDTH 9

// array depth, index is log2 of this
`define IBTB_ENTRIES 256

`endif
